// File: bench/fetch_assertions.sv
`timescale 1ns/1ns

module fetch_assertions
   import fetch_cfg_pkg::*;
   import isa_pkg::*;
(
   input logic     clk,
   input logic     rst,

   // wishbone side
   input logic     wb_cyc_o,
   input logic     wb_stb_o,
   input addr_t    wb_adr_o,
   input logic     wb_ack_i,
   input logic     wb_err_i,

   // decode handshake
   input logic     dec_valid_o,
   input logic     dec_ready_i,
   input addr_t    dec_pc_o,
   input insn_t    dec_insn_o,
   input reg_adr_t dec_rfa_o,
   input reg_adr_t dec_rfb_o,
   input logic     dec_bus_err_o
);

   // failures seen so far, read by the testbench at the end
   int fail_count = 0;

   // a reset edge leaves bus and decode output idle at the next edge
   reset_idle: assert property (@(posedge clk)
      rst |=> (!wb_cyc_o && !wb_stb_o && !dec_valid_o))
      else
      begin
         fail_count++;
         $error("bus cycle or decode valid active right after a reset edge");
      end

   // strobe only inside a cycle
   stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
      wb_stb_o |-> wb_cyc_o)
      else
      begin
         fail_count++;
         $error("wb_stb_o high while wb_cyc_o is low");
      end

   // open cycle keeps cyc, stb and address until ack or err
   bus_hold: assert property (@(posedge clk) disable iff (rst)
      (wb_cyc_o && wb_stb_o && !wb_ack_i && !wb_err_i)
      |=> (wb_cyc_o && wb_stb_o && $stable(wb_adr_o)))
      else
      begin
         fail_count++;
         $error("bus cycle dropped or address moved before ack or err");
      end

   // stalled decode output must not change
   dec_hold: assert property (@(posedge clk) disable iff (rst)
      (dec_valid_o && !dec_ready_i)
      |=> (dec_valid_o && $stable(dec_pc_o) && $stable(dec_insn_o)
           && $stable(dec_rfa_o) && $stable(dec_rfb_o) && $stable(dec_bus_err_o)))
      else
      begin
         fail_count++;
         $error("decode outputs changed while valid was held without ready");
      end

endmodule

bind fetch_top fetch_assertions u_asrt
(
   .clk           (clk),
   .rst           (rst),
   .wb_cyc_o      (wb_cyc_o),
   .wb_stb_o      (wb_stb_o),
   .wb_adr_o      (wb_adr_o),
   .wb_ack_i      (wb_ack_i),
   .wb_err_i      (wb_err_i),
   .dec_valid_o   (dec_valid_o),
   .dec_ready_i   (dec_ready_i),
   .dec_pc_o      (dec_pc_o),
   .dec_insn_o    (dec_insn_o),
   .dec_rfa_o     (dec_rfa_o),
   .dec_rfb_o     (dec_rfb_o),
   .dec_bus_err_o (dec_bus_err_o)
);

// File: bench/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb
   import fetch_cfg_pkg::*;
   import isa_pkg::*;
();

   localparam int          CLK_PERIOD  = 8;
   localparam int          RUN_TIMEOUT = 3000;
   localparam logic [15:0] LFSR_SEED   = 16'd7;
   localparam logic [15:0] LFSR_TAPS   = 16'hB400;
   localparam int          MEM_WORDS   = 256;

   // the program takes a forward j, a backward jal and then a bus error
   localparam addr_t FWD_JUMP_ADR = 32'h0000_0120;
   localparam addr_t FWD_TARGET   = 32'h0000_0180;
   localparam addr_t BWD_JUMP_ADR = 32'h0000_0194;
   localparam addr_t BWD_TARGET   = 32'h0000_0124;
   localparam addr_t ERR_ADR      = 32'h0000_0140;
   // last address accepted before the run ends
   localparam addr_t END_ADR      = 32'h0000_0240;

   logic     clk;
   logic     rst;
   logic     wb_cyc;
   logic     wb_stb;
   addr_t    wb_adr;
   logic     wb_ack;
   logic     wb_err;
   insn_t    wb_dat;
   logic     dec_valid;
   logic     dec_ready;
   addr_t    dec_pc;
   insn_t    dec_insn;
   reg_adr_t dec_rfa;
   reg_adr_t dec_rfb;
   logic     dec_bus_err;

   insn_t       mem [MEM_WORDS];
   logic [15:0] lfsr_state;
   // memory model state
   logic        cycle_open;
   int          wait_left;
   // ready stimulus state
   int          ready_draw;
   int          ready_low_left;
   // expected-sequence model
   addr_t       exp_pc;
   int          accepted;
   int          errors = 0;
   logic        run_done;
   logic        saw_fwd;
   logic        saw_bwd;
   logic        saw_bus_err;

   fetch_top uut
   (
      .clk           (clk),
      .rst           (rst),
      .wb_cyc_o      (wb_cyc),
      .wb_stb_o      (wb_stb),
      .wb_adr_o      (wb_adr),
      .wb_ack_i      (wb_ack),
      .wb_err_i      (wb_err),
      .wb_dat_i      (wb_dat),
      .dec_valid_o   (dec_valid),
      .dec_ready_i   (dec_ready),
      .dec_pc_o      (dec_pc),
      .dec_insn_o    (dec_insn),
      .dec_rfa_o     (dec_rfa),
      .dec_rfb_o     (dec_rfb),
      .dec_bus_err_o (dec_bus_err)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // one galois step whose output bit is the old lsb
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
      begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   task automatic take_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++)
      begin
         val = (val << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   // filler words use opcode 0x11 which is never a jump
   function automatic insn_t fill_word(input addr_t adr);
      addr_t mix;
      mix = adr ^ (adr << 11) ^ 32'h0012_3457;
      return {6'h11, mix[25:0]};
   endfunction

   function automatic insn_t make_jump(input opcode_t opc, input addr_t from, input addr_t to);
      int words;
      words = (int'(to) - int'(from)) / 4;
      return {opc, words[25:0]};
   endfunction

   // one accepted instruction against the image and the flow rules
   task automatic check_accept();
      insn_t       want;
      addr_t       next_pc;
      logic [25:0] disp;
      int          offset;
      want = mem[dec_pc[9:2]];
      pc_order: assert (dec_pc == exp_pc)
         else
         begin
            errors++;
            $display("CHECK FAILED dec_pc_o: got %h expected %h", dec_pc, exp_pc);
         end
      err_flag: assert (dec_bus_err == (dec_pc == ERR_ADR))
         else
         begin
            errors++;
            $display("CHECK FAILED dec_bus_err_o: got %h expected %h at %h",
               dec_bus_err, (dec_pc == ERR_ADR), dec_pc);
         end
      if (dec_bus_err)
      begin
         saw_bus_err = 1'b1;
         next_pc = BUS_ERR_VECTOR;
      end
      else
      begin
         insn_match: assert (dec_insn == want)
            else
            begin
               errors++;
               $display("CHECK FAILED dec_insn_o: got %h expected %h", dec_insn, want);
            end
         rfa_match: assert (dec_rfa == want[20:16])
            else
            begin
               errors++;
               $display("CHECK FAILED dec_rfa_o: got %h expected %h", dec_rfa, want[20:16]);
            end
         rfb_match: assert (dec_rfb == want[15:11])
            else
            begin
               errors++;
               $display("CHECK FAILED dec_rfb_o: got %h expected %h", dec_rfb, want[15:11]);
            end
         if ((want[31:26] == OPC_J) || (want[31:26] == OPC_JAL))
         begin
            // signed word displacement relative to the jump itself
            disp = want[25:0];
            offset = int'({{6{disp[25]}}, disp}) * 4;
            next_pc = dec_pc + addr_t'(offset);
            if (offset > 0)
            begin
               saw_fwd = 1'b1;
            end
            else
            begin
               saw_bwd = 1'b1;
            end
         end
         else
         begin
            next_pc = dec_pc + 32'h4;
         end
      end
      exp_pc = next_pc;
      accepted++;
      if (dec_pc == END_ADR)
      begin
         run_done = 1'b1;
      end
   endtask

   // all DUT inputs move on the falling edge
   // memory and ready draws take from one lfsr in a fixed order
   always @(negedge clk)
   begin
      if (rst)
      begin
         wb_ack = 1'b0;
         wb_err = 1'b0;
         dec_ready = 1'b0;
      end
      else
      begin
         // wishbone slave with random wait states
         if (wb_cyc && wb_stb)
         begin
            if (!cycle_open)
            begin
               cycle_open = 1'b1;
               take_bits(2, wait_left);
            end
            if (wait_left == 0)
            begin
               if (wb_adr == ERR_ADR)
               begin
                  wb_err = 1'b1;
                  wb_dat = '0;
               end
               else
               begin
                  wb_ack = 1'b1;
                  wb_dat = mem[wb_adr[9:2]];
               end
            end
            else
            begin
               wait_left--;
            end
         end
         else
         begin
            cycle_open = 1'b0;
            wb_ack = 1'b0;
            wb_err = 1'b0;
         end
         // ready with random low stretches
         if (ready_low_left > 0)
         begin
            dec_ready = 1'b0;
            ready_low_left--;
         end
         else
         begin
            take_bits(2, ready_draw);
            if (ready_draw == 0)
            begin
               take_bits(2, ready_low_left);
               dec_ready = 1'b0;
            end
            else
            begin
               dec_ready = 1'b1;
            end
         end
         // outputs are stable here and accepted at the coming rising edge
         if (dec_valid && dec_ready)
         begin
            check_accept();
         end
      end
   end

   initial
   begin
      int cycles;
      rst = 1'b1;
      wb_ack = 1'b0;
      wb_err = 1'b0;
      wb_dat = '0;
      dec_ready = 1'b0;
      lfsr_state = LFSR_SEED;
      cycle_open = 1'b0;
      wait_left = 0;
      ready_draw = 0;
      ready_low_left = 0;
      exp_pc = RESET_PC;
      accepted = 0;
      run_done = 1'b0;
      saw_fwd = 1'b0;
      saw_bwd = 1'b0;
      saw_bus_err = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         mem[i] = fill_word(addr_t'(i * 4));
      end
      mem[FWD_JUMP_ADR[9:2]] = make_jump(OPC_J, FWD_JUMP_ADR, FWD_TARGET);
      mem[BWD_JUMP_ADR[9:2]] = make_jump(OPC_JAL, BWD_JUMP_ADR, BWD_TARGET);

      // outputs stay quiet through both reset edges
      repeat (2)
      begin
         @(posedge clk);
         @(negedge clk);
         reset_quiet: assert (!wb_cyc && !wb_stb && !dec_valid)
            else
            begin
               errors++;
               $display("CHECK FAILED in reset: wb_cyc_o %h wb_stb_o %h dec_valid_o %h",
                  wb_cyc, wb_stb, dec_valid);
            end
      end
      rst <= 1'b0;

      cycles = 0;
      while (!run_done && cycles < RUN_TIMEOUT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!run_done)
      begin
         errors++;
         $display("timeout: end address was never accepted, %0d instructions seen", accepted);
      end
      if (!saw_fwd || !saw_bwd || !saw_bus_err)
      begin
         errors++;
         $display("missed behavior: forward jump %0d, backward jump %0d, bus error %0d",
            saw_fwd, saw_bwd, saw_bus_err);
      end

      $display("accepted %0d, model errors %0d, assertion failures %0d",
         accepted, errors, uut.u_asrt.fail_count);
      if (errors == 0 && uut.u_asrt.fail_count == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: hdl/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

   // byte address width of the instruction bus
   localparam int ADR_W = 32;

   typedef logic [ADR_W-1:0] addr_t;

   // first fetch address after reset
   localparam addr_t RESET_PC = 32'h0000_0100;

   // handler address taken after an instruction bus error
   localparam addr_t BUS_ERR_VECTOR = 32'h0000_0200;

   // byte distance between sequential instruction words
   localparam addr_t PC_STEP = 32'h0000_0004;

   // queue entries, one slot is kept for the word in flight
   localparam int QUEUE_DEPTH = 4;
   localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);

   // queue slot index and fill level
   typedef logic [QUEUE_AW-1:0] q_ptr_t;
   typedef logic [QUEUE_AW:0]   q_cnt_t;

endpackage

// File: hdl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top
   import fetch_cfg_pkg::*;
   import isa_pkg::*;
(
   input  logic     clk,
   input  logic     rst,

   // wishbone classic instruction bus
   output logic     wb_cyc_o,
   output logic     wb_stb_o,
   output addr_t    wb_adr_o,
   input  logic     wb_ack_i,
   input  logic     wb_err_i,
   input  insn_t    wb_dat_i,

   // decoded instruction handshake
   output logic     dec_valid_o,
   input  logic     dec_ready_i,
   output addr_t    dec_pc_o,
   output insn_t    dec_insn_o,
   output reg_adr_t dec_rfa_o,
   output reg_adr_t dec_rfb_o,
   output logic     dec_bus_err_o
);

   // fetch to queue
   logic  q_wr;
   addr_t q_wr_pc;
   insn_t q_wr_insn;
   logic  q_wr_err;
   logic  q_full;

   // queue to decode
   logic  q_empty;
   logic  q_rd;
   addr_t q_rd_pc;
   insn_t q_rd_insn;
   logic  q_rd_err;

   // decode back to fetch, same pulse flushes the queue
   logic  redir_valid;
   addr_t redir_pc;

   insn_fetch u_fetch
   (
      .clk           (clk),
      .rst           (rst),
      .wb_cyc_o      (wb_cyc_o),
      .wb_stb_o      (wb_stb_o),
      .wb_adr_o      (wb_adr_o),
      .wb_ack_i      (wb_ack_i),
      .wb_err_i      (wb_err_i),
      .wb_dat_i      (wb_dat_i),
      .q_full_i      (q_full),
      .q_wr_o        (q_wr),
      .q_wr_pc_o     (q_wr_pc),
      .q_wr_insn_o   (q_wr_insn),
      .q_wr_err_o    (q_wr_err),
      .redir_valid_i (redir_valid),
      .redir_pc_i    (redir_pc)
   );

   insn_queue u_queue
   (
      .clk       (clk),
      .rst       (rst),
      .flush_i   (redir_valid),
      .wr_i      (q_wr),
      .wr_pc_i   (q_wr_pc),
      .wr_insn_i (q_wr_insn),
      .wr_err_i  (q_wr_err),
      .full_o    (q_full),
      .empty_o   (q_empty),
      .rd_i      (q_rd),
      .rd_pc_o   (q_rd_pc),
      .rd_insn_o (q_rd_insn),
      .rd_err_o  (q_rd_err)
   );

   insn_decode u_decode
   (
      .clk           (clk),
      .rst           (rst),
      .q_empty_i     (q_empty),
      .q_rd_o        (q_rd),
      .q_pc_i        (q_rd_pc),
      .q_insn_i      (q_rd_insn),
      .q_err_i       (q_rd_err),
      .redir_valid_o (redir_valid),
      .redir_pc_o    (redir_pc),
      .dec_valid_o   (dec_valid_o),
      .dec_ready_i   (dec_ready_i),
      .dec_pc_o      (dec_pc_o),
      .dec_insn_o    (dec_insn_o),
      .dec_rfa_o     (dec_rfa_o),
      .dec_rfb_o     (dec_rfb_o),
      .dec_bus_err_o (dec_bus_err_o)
   );

endmodule

// File: hdl/insn_decode.sv
`timescale 1ns/1ns

module insn_decode
   import fetch_cfg_pkg::*;
   import isa_pkg::*;
(
   input  logic     clk,
   input  logic     rst,

   // queue head
   input  logic     q_empty_i,
   output logic     q_rd_o,
   input  addr_t    q_pc_i,
   input  insn_t    q_insn_i,
   input  logic     q_err_i,

   // redirect to fetch, also flushes the queue
   output logic     redir_valid_o,
   output addr_t    redir_pc_o,

   // decoded instruction towards execute
   output logic     dec_valid_o,
   input  logic     dec_ready_i,
   output addr_t    dec_pc_o,
   output insn_t    dec_insn_o,
   output reg_adr_t dec_rfa_o,
   output reg_adr_t dec_rfb_o,
   output logic     dec_bus_err_o
);

   // output register
   logic    out_valid;
   addr_t   out_pc;
   insn_t   out_insn;
   logic    out_err;
   // entry changes the flow, target is precomputed at load
   logic    out_redir;
   addr_t   out_target;

   opcode_t head_opc;
   disp_t   head_disp;
   logic    head_is_jump;
   addr_t   head_jump_pc;
   logic    accept;
   logic    load;

   // look at the head entry before it is loaded
   assign head_opc     = q_insn_i[OPC_HI:OPC_LO];
   assign head_disp    = q_insn_i[DISP_W-1:0];
   assign head_is_jump = (head_opc == OPC_J) || (head_opc == OPC_JAL);

   // word offset, sign extended and scaled to bytes
   assign head_jump_pc = q_pc_i +
      {{(ADR_W-DISP_W-2){head_disp[DISP_W-1]}}, head_disp, 2'b00};

   assign accept = out_valid && dec_ready_i;

   // redirect fires as the jump or error entry leaves the stage
   assign redir_valid_o = accept && out_redir;
   assign redir_pc_o    = out_target;

   // refill when empty or draining, but not from a head about to be flushed
   assign load   = !q_empty_i && (!out_valid || accept) && !redir_valid_o;
   assign q_rd_o = load;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
         out_insn  <= NOP_INSN;
         out_err   <= 1'b0;
         out_redir <= 1'b0;
      end
      else if (load)
      begin
         out_valid <= 1'b1;
         out_insn  <= q_insn_i;
         out_err   <= q_err_i;
         out_redir <= q_err_i || head_is_jump;
      end
      else if (accept)
      begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         out_pc <= q_pc_i;
         // errored word is garbage, go to the handler instead
         out_target <= q_err_i ? BUS_ERR_VECTOR : head_jump_pc;
      end
   end

   assign dec_valid_o   = out_valid;
   assign dec_pc_o      = out_pc;
   assign dec_insn_o    = out_insn;
   assign dec_bus_err_o = out_err;
   // source register indices straight from the held word
   assign dec_rfa_o     = out_insn[RA_HI:RA_LO];
   assign dec_rfb_o     = out_insn[RB_HI:RB_LO];

endmodule

// File: hdl/insn_fetch.sv
`timescale 1ns/1ns

module insn_fetch
   import fetch_cfg_pkg::*;
   import isa_pkg::*;
(
   input  logic  clk,
   input  logic  rst,

   // wishbone classic master, instruction side
   output logic  wb_cyc_o,
   output logic  wb_stb_o,
   output addr_t wb_adr_o,
   input  logic  wb_ack_i,
   input  logic  wb_err_i,
   input  insn_t wb_dat_i,

   // queue write side
   input  logic  q_full_i,
   output logic  q_wr_o,
   output addr_t q_wr_pc_o,
   output insn_t q_wr_insn_o,
   output logic  q_wr_err_o,

   // redirect from decode
   input  logic  redir_valid_i,
   input  addr_t redir_pc_i
);

   typedef enum logic [1:0]
   {
      FETCH_IDLE,
      FETCH_BUS,
      FETCH_HALTED
   } fetch_state_e;

   fetch_state_e state;
   fetch_state_e state_nxt;

   // next word address to request
   addr_t pc;
   // address of the cycle on the bus, frozen for the whole cycle
   addr_t bus_adr;
   // in-flight cycle was overtaken by a redirect
   logic  stale;

   logic  bus_done;
   logic  word_keep;
   logic  start_cycle;

   // ack or err terminates the cycle on this edge
   assign bus_done = (state == FETCH_BUS) && (wb_ack_i || wb_err_i);

   // word goes into the queue unless a redirect made it useless
   assign word_keep = bus_done && !stale && !redir_valid_i;

   // a new cycle needs queue room for the word it brings
   assign start_cycle = (state == FETCH_IDLE) && !q_full_i && !redir_valid_i;

   always_comb
   begin
      state_nxt = state;
      case (state)
         FETCH_IDLE:
         begin
            if (start_cycle)
            begin
               state_nxt = FETCH_BUS;
            end
         end
         FETCH_BUS:
         begin
            // a kept error parks the unit, anything else returns to idle
            if (bus_done)
            begin
               state_nxt = (word_keep && wb_err_i) ? FETCH_HALTED : FETCH_IDLE;
            end
         end
         FETCH_HALTED:
         begin
            // only a redirect gets fetching going again
            if (redir_valid_i)
            begin
               state_nxt = FETCH_IDLE;
            end
         end
         default:
         begin
            state_nxt = FETCH_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= FETCH_IDLE;
         pc    <= RESET_PC;
         stale <= 1'b0;
      end
      else
      begin
         state <= state_nxt;

         // redirect wins over sequential advance
         if (redir_valid_i)
         begin
            pc <= redir_pc_i;
         end
         else if (word_keep && !wb_err_i)
         begin
            pc <= pc + PC_STEP;
         end

         // stale flag lives only until its cycle terminates
         if (bus_done)
         begin
            stale <= 1'b0;
         end
         else if (redir_valid_i && (state == FETCH_BUS))
         begin
            stale <= 1'b1;
         end
      end
   end

   // cycle address captured at cycle start
   always_ff @(posedge clk)
   begin
      if (start_cycle)
      begin
         bus_adr <= pc;
      end
   end

   // cyc and stb always move together, single word per cycle
   assign wb_cyc_o = (state == FETCH_BUS);
   assign wb_stb_o = (state == FETCH_BUS);
   assign wb_adr_o = bus_adr;

   // queue is written on the same edge that samples ack or err
   assign q_wr_o      = word_keep;
   assign q_wr_pc_o   = bus_adr;
   assign q_wr_insn_o = wb_dat_i;
   assign q_wr_err_o  = wb_err_i;

endmodule

// File: hdl/insn_queue.sv
`timescale 1ns/1ns

module insn_queue
   import fetch_cfg_pkg::*;
   import isa_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  flush_i,

   // write side, from fetch
   input  logic  wr_i,
   input  addr_t wr_pc_i,
   input  insn_t wr_insn_i,
   input  logic  wr_err_i,

   output logic  full_o,
   output logic  empty_o,

   // read side, head entry to decode
   input  logic  rd_i,
   output addr_t rd_pc_o,
   output insn_t rd_insn_o,
   output logic  rd_err_o
);

   // entry storage, split per field
   addr_t  pc_mem   [QUEUE_DEPTH];
   insn_t  insn_mem [QUEUE_DEPTH];
   logic   err_mem  [QUEUE_DEPTH];

   q_ptr_t wr_ptr;
   q_ptr_t rd_ptr;
   q_cnt_t count;

   logic   do_wr;
   logic   do_rd;

   // flush drops everything, including a write or read in the same clock
   assign do_wr = wr_i && !flush_i && (count != q_cnt_t'(QUEUE_DEPTH));
   assign do_rd = rd_i && !flush_i && (count != '0);

   always_ff @(posedge clk)
   begin
      if (rst || flush_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // depth is a power of two so the pointers wrap by themselves
         if (do_wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd)
         begin
            count <= count + 1'b1;
         end
         else if (do_rd && !do_wr)
         begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_wr)
      begin
         pc_mem[wr_ptr]   <= wr_pc_i;
         insn_mem[wr_ptr] <= wr_insn_i;
         err_mem[wr_ptr]  <= wr_err_i;
      end
   end

   // head read from storage only, a new entry shows one clock after its write
   assign rd_pc_o   = pc_mem[rd_ptr];
   assign rd_insn_o = insn_mem[rd_ptr];
   assign rd_err_o  = err_mem[rd_ptr];

   assign empty_o = (count == '0);
   // last slot stays free for the word still on the bus
   assign full_o  = (count >= q_cnt_t'(QUEUE_DEPTH - 1));

endmodule

// File: hdl/isa_pkg.sv
package isa_pkg;

   // instruction word and field widths
   localparam int INSN_W    = 32;
   localparam int OPCODE_W  = 6;
   localparam int REG_ADR_W = 5;
   localparam int DISP_W    = 26;

   // one full instruction word as fetched from the bus
   typedef logic [INSN_W-1:0] insn_t;

   // major opcode, top six bits of the word
   typedef logic [OPCODE_W-1:0] opcode_t;

   // general purpose register index
   typedef logic [REG_ADR_W-1:0] reg_adr_t;

   // jump displacement, signed word offset from the jump itself
   typedef logic [DISP_W-1:0] disp_t;

   // major opcode field
   localparam int OPC_HI = 31;
   localparam int OPC_LO = 26;

   // first source register
   localparam int RA_HI = 20;
   localparam int RA_LO = 16;

   // second source register
   localparam int RB_HI = 15;
   localparam int RB_LO = 11;

   // unconditional jumps, displacement in bits 25..0
   localparam opcode_t OPC_J   = 6'h00;
   localparam opcode_t OPC_JAL = 6'h01;

   // nop word, shown on the decode output before the first fetch
   localparam insn_t NOP_INSN = 32'h1500_0000;

endpackage

// File: sim.f
hdl/isa_pkg.sv
hdl/fetch_cfg_pkg.sv
hdl/insn_fetch.sv
hdl/insn_queue.sv
hdl/insn_decode.sv
hdl/fetch_top.sv
bench/fetch_assertions.sv
bench/fetch_tb.sv
